// File: rtl/bpu_pkg.sv
package bpu_pkg;

  localparam int unsigned XLEN = 32;
  localparam int unsigned INSTR_PER_FETCH = 4;
  localparam int unsigned FETCH_BYTES = 16;

  // BTB size the stored tag is sized for.
  localparam int unsigned BTB_ENTRIES_DEF = 128;
  localparam int unsigned BTB_TAG_W = XLEN - 2 - $clog2(BTB_ENTRIES_DEF);

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [$clog2(INSTR_PER_FETCH)-1:0] slot_idx_t;
  typedef logic [1:0] ctr_t;  // 2-bit saturating counter.
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  typedef struct packed {
    logic valid;
    logic ready;
  } handshake_t;

  typedef struct packed {
    addr_t pc;
  } ifu_to_bpu_t;

  typedef struct packed {
    addr_t     npc;
    logic      pred_slot_valid;
    slot_idx_t pred_slot_idx;
    addr_t     pred_slot_target;
  } bpu_to_ifu_t;

  // Commit-side training.
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  is_cond;
    logic  taken;
    addr_t target;
    logic  is_call;
    logic  is_ret;
  } bpu_update_t;

  typedef struct packed {
    logic  valid;
    logic  is_call;
    logic  is_ret;
    addr_t pc;  // PC of the retiring call or return.
  } ras_update_t;

  typedef struct packed {
    addr_t    target;
    logic     is_cond;
    logic     is_call;
    logic     is_ret;
    btb_tag_t tag;
  } btb_entry_t;

endpackage

// File: rtl/bpu_btb.sv
`timescale 1ns/1ps

module bpu_btb import bpu_pkg::*; #(
  parameter int unsigned BTB_ENTRIES = BTB_ENTRIES_DEF,
  parameter bit BTB_HASH_ENABLE = 1'b1
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  addr_t       lookup_pc_i [INSTR_PER_FETCH],
  output logic        hit_o [INSTR_PER_FETCH],
  output btb_entry_t  entry_o [INSTR_PER_FETCH],
  input  bpu_update_t upd_i
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

  typedef logic [IDX_W-1:0] idx_t;

  btb_entry_t mem_q [BTB_ENTRIES];
  logic [BTB_ENTRIES-1:0] valid_q;

  idx_t       wr_idx;
  logic       wr_en;
  btb_entry_t wr_entry;

  function automatic idx_t get_idx(input addr_t pc);
    idx_t idx;
    idx = pc[2 +: IDX_W];
    if (BTB_HASH_ENABLE) begin
      idx = idx ^ pc[2 + IDX_W +: IDX_W];  // Fold in the next bits up.
    end
    return idx;
  endfunction

  function automatic btb_tag_t get_tag(input addr_t pc);
    return btb_tag_t'(pc >> (2 + IDX_W));
  endfunction

  always_comb begin
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      entry_o[i] = mem_q[get_idx(lookup_pc_i[i])];
      hit_o[i]   = valid_q[get_idx(lookup_pc_i[i])] &&
                   (entry_o[i].tag == get_tag(lookup_pc_i[i]));
    end
  end

  // Not-taken conditionals never allocate.
  assign wr_en  = upd_i.valid && (!upd_i.is_cond || upd_i.taken);
  assign wr_idx = get_idx(upd_i.pc);

  always_comb begin
    wr_entry         = '0;
    wr_entry.target  = upd_i.target;
    wr_entry.is_cond = upd_i.is_cond;
    wr_entry.is_call = upd_i.is_call;
    wr_entry.is_ret  = upd_i.is_ret;
    wr_entry.tag     = get_tag(upd_i.pc);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_idx] <= wr_entry;
    end
  end

endmodule

// File: rtl/bpu_bht.sv
`timescale 1ns/1ps

module bpu_bht import bpu_pkg::*; #(
  parameter int unsigned BHT_ENTRIES = 512,
  parameter bit BHT_HASH_ENABLE = 1'b1,
  parameter bit USE_GSHARE = 1'b0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  addr_t       lookup_pc_i [INSTR_PER_FETCH],
  output logic        taken_o [INSTR_PER_FETCH],
  input  bpu_update_t upd_i
);

  localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

  typedef logic [IDX_W-1:0] idx_t;

  ctr_t cnt_q [BHT_ENTRIES];
  idx_t ghr_q;  // Global history, newest outcome in bit 0.
  idx_t upd_idx;
  ctr_t upd_cnt;

  function automatic idx_t get_idx(input addr_t pc, input idx_t ghr);
    idx_t idx;
    idx = pc[2 +: IDX_W];
    if (BHT_HASH_ENABLE) begin
      idx = idx ^ pc[2 + IDX_W +: IDX_W];
    end
    if (USE_GSHARE) begin
      idx = idx ^ ghr;
    end
    return idx;
  endfunction

  always_comb begin
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      taken_o[i] = cnt_q[get_idx(lookup_pc_i[i], ghr_q)][1];  // 2 or 3.
    end
  end

  assign upd_idx = get_idx(upd_i.pc, ghr_q);
  assign upd_cnt = cnt_q[upd_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'd1;  // Weakly not taken.
      end
      ghr_q <= '0;
    end else if (upd_i.valid && upd_i.is_cond) begin
      if (upd_i.taken && upd_cnt != 2'd3) begin
        cnt_q[upd_idx] <= upd_cnt + 2'd1;
      end else if (!upd_i.taken && upd_cnt != 2'd0) begin
        cnt_q[upd_idx] <= upd_cnt - 2'd1;
      end
      ghr_q <= {ghr_q[IDX_W-2:0], upd_i.taken};
    end
  end

endmodule

// File: rtl/bpu_ras.sv
`timescale 1ns/1ps

module bpu_ras import bpu_pkg::*; #(
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  ras_update_t ras_i,
  output logic        top_valid_o,
  output addr_t       top_o
);

  localparam int unsigned PTR_W = $clog2(RAS_DEPTH);
  localparam int unsigned CNT_W = $clog2(RAS_DEPTH + 1);

  addr_t stack_q [RAS_DEPTH];
  logic [PTR_W-1:0] top_q;  // Slot of the current top.
  logic [CNT_W-1:0] cnt_q;
  logic [PTR_W-1:0] top_inc;
  logic [PTR_W-1:0] top_dec;
  logic push;
  logic pop;
  logic swap;
  addr_t ret_addr;

  assign top_inc  = (top_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_q + 1'b1;
  assign top_dec  = (top_q == '0) ? PTR_W'(RAS_DEPTH - 1) : top_q - 1'b1;
  assign ret_addr = ras_i.pc + addr_t'(4);

  assign push = ras_i.valid && ras_i.is_call && !ras_i.is_ret;
  assign pop  = ras_i.valid && ras_i.is_ret && !ras_i.is_call;
  assign swap = ras_i.valid && ras_i.is_call && ras_i.is_ret;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      top_q <= '0;
      cnt_q <= '0;
    end else if (push) begin
      top_q <= top_inc;  // Wraps over the oldest entry when full.
      if (cnt_q != CNT_W'(RAS_DEPTH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop && cnt_q != '0) begin
      top_q <= top_dec;
      cnt_q <= cnt_q - 1'b1;
    end else if (swap && cnt_q == '0) begin
      cnt_q <= CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      stack_q[top_inc] <= ret_addr;
    end else if (swap) begin
      stack_q[top_q] <= ret_addr;
    end
  end

  assign top_valid_o = (cnt_q != '0);
  assign top_o       = stack_q[top_q];

endmodule

// File: rtl/bpu.sv
`timescale 1ns/1ps

module bpu import bpu_pkg::*; #(
  parameter int unsigned BTB_ENTRIES = BTB_ENTRIES_DEF,
  parameter int unsigned BHT_ENTRIES = 512,
  parameter bit BTB_HASH_ENABLE = 1'b1,
  parameter bit BHT_HASH_ENABLE = 1'b1,
  parameter bit USE_GSHARE = 1'b0,
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  handshake_t  ifu_to_bpu_handshake_i,
  input  ifu_to_bpu_t ifu_to_bpu_i,
  output handshake_t  bpu_to_ifu_handshake_o,
  output bpu_to_ifu_t bpu_to_ifu_o,
  input  logic        ifu_ready_i,
  input  bpu_update_t upd_i,
  input  ras_update_t ras_i,
  input  logic        flush_i
);

  localparam int unsigned OFF_W  = $clog2(FETCH_BYTES);
  localparam int unsigned SLOT_W = $bits(slot_idx_t);

  addr_t      base_pc;
  slot_idx_t  start_slot;
  addr_t      slot_pc [INSTR_PER_FETCH];
  logic       btb_hit [INSTR_PER_FETCH];
  btb_entry_t btb_entry [INSTR_PER_FETCH];
  logic       bht_taken [INSTR_PER_FETCH];
  logic       ras_top_valid;
  addr_t      ras_top;
  logic [INSTR_PER_FETCH-1:0] slot_taken;
  addr_t      slot_target [INSTR_PER_FETCH];

  bpu_to_ifu_t pred_d;
  bpu_to_ifu_t resp_q;
  logic        resp_valid_q;
  logic        req_ready;
  logic        req_accept;

  always_comb begin
    base_pc    = {ifu_to_bpu_i.pc[XLEN-1:OFF_W], {OFF_W{1'b0}}};
    start_slot = ifu_to_bpu_i.pc[2 +: SLOT_W];
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      slot_pc[i] = base_pc + addr_t'(4 * i);
    end
  end

  bpu_btb #(
    .BTB_ENTRIES    (BTB_ENTRIES),
    .BTB_HASH_ENABLE(BTB_HASH_ENABLE)
  ) u_btb (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .lookup_pc_i(slot_pc),
    .hit_o      (btb_hit),
    .entry_o    (btb_entry),
    .upd_i      (upd_i)
  );

  bpu_bht #(
    .BHT_ENTRIES    (BHT_ENTRIES),
    .BHT_HASH_ENABLE(BHT_HASH_ENABLE),
    .USE_GSHARE     (USE_GSHARE)
  ) u_bht (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .lookup_pc_i(slot_pc),
    .taken_o    (bht_taken),
    .upd_i      (upd_i)
  );

  bpu_ras #(
    .RAS_DEPTH(RAS_DEPTH)
  ) u_ras (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ras_i      (ras_i),
    .top_valid_o(ras_top_valid),
    .top_o      (ras_top)
  );

  // Slots before the fetch PC are never predicted.
  always_comb begin
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      slot_target[i] = (btb_entry[i].is_ret && ras_top_valid) ? ras_top
                                                               : btb_entry[i].target;
      slot_taken[i]  = (i >= int'(start_slot)) && btb_hit[i] &&
                       (btb_entry[i].is_call || btb_entry[i].is_ret ||
                        !btb_entry[i].is_cond || bht_taken[i]);
    end
  end

  // Walk down so the lowest taken slot is the last one written.
  always_comb begin
    pred_d     = '0;
    pred_d.npc = base_pc + addr_t'(FETCH_BYTES);
    for (int i = INSTR_PER_FETCH - 1; i >= 0; i--) begin
      if (slot_taken[i]) begin
        pred_d.pred_slot_valid  = 1'b1;
        pred_d.pred_slot_idx    = slot_idx_t'(i);
        pred_d.pred_slot_target = slot_target[i];
        pred_d.npc              = slot_target[i];
      end
    end
  end

  assign req_ready  = (!resp_valid_q || ifu_ready_i) && !flush_i;
  assign req_accept = ifu_to_bpu_handshake_i.valid && req_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (flush_i) begin
      resp_valid_q <= 1'b0;  // Drop the prediction in flight.
    end else if (req_accept) begin
      resp_valid_q <= 1'b1;
    end else if (ifu_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      resp_q <= pred_d;
    end
  end

  assign bpu_to_ifu_handshake_o.valid = resp_valid_q;
  assign bpu_to_ifu_handshake_o.ready = req_ready;
  assign bpu_to_ifu_o                 = resp_q;

endmodule

// File: rtl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; #(
  parameter int unsigned BTB_ENTRIES = BTB_ENTRIES_DEF,
  parameter int unsigned BHT_ENTRIES = 512,
  parameter bit BTB_HASH_ENABLE = 1'b1,
  parameter bit BHT_HASH_ENABLE = 1'b1,
  parameter bit USE_GSHARE = 1'b0,  // Set to 1 for gshare builds.
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      ifu_valid_i,
  input  logic      ifu_ready_i,
  input  addr_t     pc_i,
  input  logic      update_valid_i,
  input  addr_t     update_pc_i,
  input  logic      update_is_cond_i,
  input  logic      update_taken_i,
  input  addr_t     update_target_i,
  input  logic      update_is_call_i,
  input  logic      update_is_ret_i,
  input  logic      ras_update_valid_i,
  input  logic      ras_update_is_call_i,
  input  logic      ras_update_is_ret_i,
  input  addr_t     ras_update_pc_i,
  input  logic      flush_i,
  output logic      req_ready_o,
  output logic      pred_valid_o,
  output addr_t     npc_o,
  output logic      pred_slot_valid_o,
  output slot_idx_t pred_slot_idx_o,
  output addr_t     pred_slot_target_o
);

  handshake_t  ifu_to_bpu_handshake;
  handshake_t  bpu_to_ifu_handshake;
  ifu_to_bpu_t ifu_to_bpu;
  bpu_to_ifu_t bpu_to_ifu;
  bpu_update_t upd;
  ras_update_t ras_upd;

  assign ifu_to_bpu_handshake.valid = ifu_valid_i;
  assign ifu_to_bpu_handshake.ready = ifu_ready_i;
  assign ifu_to_bpu.pc              = pc_i;

  assign upd.valid   = update_valid_i;
  assign upd.pc      = update_pc_i;
  assign upd.is_cond = update_is_cond_i;
  assign upd.taken   = update_taken_i;
  assign upd.target  = update_target_i;
  assign upd.is_call = update_is_call_i;
  assign upd.is_ret  = update_is_ret_i;

  assign ras_upd.valid   = ras_update_valid_i;
  assign ras_upd.is_call = ras_update_is_call_i;
  assign ras_upd.is_ret  = ras_update_is_ret_i;
  assign ras_upd.pc      = ras_update_pc_i;

  bpu #(
    .BTB_ENTRIES    (BTB_ENTRIES),
    .BHT_ENTRIES    (BHT_ENTRIES),
    .BTB_HASH_ENABLE(BTB_HASH_ENABLE),
    .BHT_HASH_ENABLE(BHT_HASH_ENABLE),
    .USE_GSHARE     (USE_GSHARE),
    .RAS_DEPTH      (RAS_DEPTH)
  ) u_bpu (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .ifu_to_bpu_handshake_i(ifu_to_bpu_handshake),
    .ifu_to_bpu_i          (ifu_to_bpu),
    .bpu_to_ifu_handshake_o(bpu_to_ifu_handshake),
    .bpu_to_ifu_o          (bpu_to_ifu),
    .ifu_ready_i           (ifu_ready_i),
    .upd_i                 (upd),
    .ras_i                 (ras_upd),
    .flush_i               (flush_i)
  );

  assign req_ready_o        = bpu_to_ifu_handshake.ready;
  assign pred_valid_o       = bpu_to_ifu_handshake.valid;
  assign npc_o              = bpu_to_ifu.npc;
  assign pred_slot_valid_o  = bpu_to_ifu.pred_slot_valid;
  assign pred_slot_idx_o    = bpu_to_ifu.pred_slot_idx;
  assign pred_slot_target_o = bpu_to_ifu.pred_slot_target;

endmodule

// File: tb/bpu_tb_tasks.svh
`ifndef BPU_TB_TASKS_SVH
`define BPU_TB_TASKS_SVH

task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopping at the first mismatch.");
  end
endtask

// Compares the registered response with a model prediction.
task automatic check_response(input string name, input bpu_to_ifu_t exp);
  check_eq({name, ": pred_valid"}, 64'd1, pred_valid);
  check_eq({name, ": npc"}, exp.npc, npc);
  check_eq({name, ": slot_valid"}, exp.pred_slot_valid, pred_slot_valid);
  if (exp.pred_slot_valid) begin
    check_eq({name, ": slot_idx"}, exp.pred_slot_idx, pred_slot_idx);
    check_eq({name, ": slot_target"}, exp.pred_slot_target, pred_slot_target);
  end
endtask

task automatic request(input string name, input addr_t req_pc);
  bpu_to_ifu_t exp;
  @(negedge clk);
  exp = predict(req_pc);
  ifu_valid = 1'b1;
  fetch_pc = req_pc;
  while (!req_ready) begin
    @(negedge clk);
  end
  @(negedge clk);  // Response is due one cycle after acceptance.
  ifu_valid = 1'b0;
  check_response(name, exp);
endtask

task automatic train(input addr_t upd_addr, input logic is_cond, input logic taken,
                     input addr_t target, input logic is_call, input logic is_ret);
  @(negedge clk);
  upd_valid = 1'b1;
  upd_pc = upd_addr;
  upd_is_cond = is_cond;
  upd_taken = taken;
  upd_target = target;
  upd_is_call = is_call;
  upd_is_ret = is_ret;
  @(negedge clk);
  upd_valid = 1'b0;
  model_train(upd_addr, is_cond, taken, target, is_call, is_ret);
endtask

task automatic retire(input addr_t ret_pc, input logic is_call, input logic is_ret);
  @(negedge clk);
  ras_valid = 1'b1;
  ras_pc = ret_pc;
  ras_is_call = is_call;
  ras_is_ret = is_ret;
  @(negedge clk);
  ras_valid = 1'b0;
  model_ras(ret_pc, is_call, is_ret);
endtask

`endif

// File: tb/tb_bpu_top.sv
`timescale 1ns/1ps

module tb_bpu_top import bpu_pkg::*; ;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam logic [31:0] RAND_SEED = 32'ha654_5419;
  localparam int BTB_N = 128;
  localparam int BHT_N = 512;
  localparam int BTB_IDX_W = 7;
  localparam int BHT_IDX_W = 9;
  localparam int RAS_N = 8;
  localparam int COLD_REQS = 8;
  localparam int HOLD_CYCLES = 3;

  // Cycle budget of each test.
  localparam int COLD_CYCLES = COLD_REQS + 2;
  localparam int JUMP_CYCLES = 12;
  localparam int COND_CYCLES = 24;
  localparam int RAS_CYCLES = 16;
  localparam int BP_CYCLES = HOLD_CYCLES + 8;
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + COLD_CYCLES + JUMP_CYCLES +
                                        COND_CYCLES + RAS_CYCLES + BP_CYCLES);

  localparam addr_t JMP_BASE = 32'h0000_1000;
  localparam addr_t ALIAS_BASE = 32'h0001_1000;  // Same BTB index, other tag.
  localparam addr_t COND_BASE = 32'h0000_4000;
  localparam addr_t COND_PC = 32'h0000_4008;
  localparam addr_t RET_BASE = 32'h0000_6000;
  localparam addr_t RET_PC = 32'h0000_6004;

  logic      clk;
  logic      rst;
  logic      ifu_valid;
  logic      ifu_ready;
  addr_t     fetch_pc;
  logic      upd_valid;
  addr_t     upd_pc;
  logic      upd_is_cond;
  logic      upd_taken;
  addr_t     upd_target;
  logic      upd_is_call;
  logic      upd_is_ret;
  logic      ras_valid;
  logic      ras_is_call;
  logic      ras_is_ret;
  addr_t     ras_pc;
  logic      flush;
  logic      req_ready;
  logic      pred_valid;
  addr_t     npc;
  logic      pred_slot_valid;
  slot_idx_t pred_slot_idx;
  addr_t     pred_slot_target;

  // Shadow predictor state.
  bit    m_btb_valid [BTB_N];
  logic [XLEN-3-BTB_IDX_W:0] m_btb_tag [BTB_N];
  addr_t m_btb_target [BTB_N];
  bit    m_btb_cond [BTB_N];
  bit    m_btb_call [BTB_N];
  bit    m_btb_ret [BTB_N];
  ctr_t  m_bht [BHT_N];
  addr_t m_ras [$];

  bpu_top #(
    .BTB_ENTRIES    (BTB_N),
    .BHT_ENTRIES    (BHT_N),
    .BTB_HASH_ENABLE(1'b1),
    .BHT_HASH_ENABLE(1'b1),
    .USE_GSHARE     (1'b0),
    .RAS_DEPTH      (RAS_N)
  ) u_bpu_top (
    .clk_i               (clk),
    .rst_i               (rst),
    .ifu_valid_i         (ifu_valid),
    .ifu_ready_i         (ifu_ready),
    .pc_i                (fetch_pc),
    .update_valid_i      (upd_valid),
    .update_pc_i         (upd_pc),
    .update_is_cond_i    (upd_is_cond),
    .update_taken_i      (upd_taken),
    .update_target_i     (upd_target),
    .update_is_call_i    (upd_is_call),
    .update_is_ret_i     (upd_is_ret),
    .ras_update_valid_i  (ras_valid),
    .ras_update_is_call_i(ras_is_call),
    .ras_update_is_ret_i (ras_is_ret),
    .ras_update_pc_i     (ras_pc),
    .flush_i             (flush),
    .req_ready_o         (req_ready),
    .pred_valid_o        (pred_valid),
    .npc_o               (npc),
    .pred_slot_valid_o   (pred_slot_valid),
    .pred_slot_idx_o     (pred_slot_idx),
    .pred_slot_target_o  (pred_slot_target)
  );

  function automatic int btb_index(input addr_t a);
    return int'(a[2 +: BTB_IDX_W] ^ a[2 + BTB_IDX_W +: BTB_IDX_W]);
  endfunction

  function automatic int bht_index(input addr_t a);
    return int'(a[2 +: BHT_IDX_W] ^ a[2 + BHT_IDX_W +: BHT_IDX_W]);
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < BTB_N; i++) begin
      m_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < BHT_N; i++) begin
      m_bht[i] = 2'd1;
    end
    m_ras.delete();
  endfunction

  function automatic void model_train(input addr_t a, input logic is_cond, input logic taken,
                                      input addr_t target, input logic is_call,
                                      input logic is_ret);
    int bi;
    int hi;
    bi = btb_index(a);
    hi = bht_index(a);
    if (!is_cond || taken) begin
      m_btb_valid[bi] = 1'b1;
      m_btb_tag[bi] = a[XLEN-1:2+BTB_IDX_W];
      m_btb_target[bi] = target;
      m_btb_cond[bi] = is_cond;
      m_btb_call[bi] = is_call;
      m_btb_ret[bi] = is_ret;
    end
    if (is_cond && taken && m_bht[hi] != 2'd3) begin
      m_bht[hi] = m_bht[hi] + 2'd1;
    end else if (is_cond && !taken && m_bht[hi] != 2'd0) begin
      m_bht[hi] = m_bht[hi] - 2'd1;
    end
  endfunction

  function automatic void model_ras(input addr_t a, input logic is_call, input logic is_ret);
    if (is_call && is_ret) begin
      if (m_ras.size() == 0) begin
        m_ras.push_back(a + 32'd4);
      end else begin
        m_ras[m_ras.size() - 1] = a + 32'd4;
      end
    end else if (is_call) begin
      m_ras.push_back(a + 32'd4);
      if (m_ras.size() > RAS_N) begin
        void'(m_ras.pop_front());  // Oldest entry is lost.
      end
    end else if (is_ret && m_ras.size() != 0) begin
      void'(m_ras.pop_back());
    end
  endfunction

  function automatic bpu_to_ifu_t predict(input addr_t a);
    bpu_to_ifu_t p;
    addr_t base;
    addr_t spc;
    int bi;
    logic hit;
    logic taken;
    p = '0;
    base = {a[XLEN-1:4], 4'h0};
    p.npc = base + addr_t'(FETCH_BYTES);
    for (int s = int'(a[3:2]); s < INSTR_PER_FETCH; s++) begin
      spc = base + addr_t'(4 * s);
      bi = btb_index(spc);
      hit = m_btb_valid[bi] && (m_btb_tag[bi] == spc[XLEN-1:2+BTB_IDX_W]);
      taken = hit && (m_btb_call[bi] || m_btb_ret[bi] || !m_btb_cond[bi] ||
                      m_bht[bht_index(spc)] >= 2'd2);
      if (taken && !p.pred_slot_valid) begin
        p.pred_slot_valid = 1'b1;
        p.pred_slot_idx = slot_idx_t'(s);
        p.pred_slot_target = (m_btb_ret[bi] && m_ras.size() != 0) ? m_ras[$]
                                                                  : m_btb_target[bi];
        p.npc = p.pred_slot_target;
      end
    end
    return p;
  endfunction

`include "bpu_tb_tasks.svh"

  task automatic test_cold_tables();
    bpu_to_ifu_t exp;
    addr_t req_pc;
    check_eq("cold: pred_valid after reset", 64'd0, pred_valid);
    check_eq("cold: req_ready after reset", 64'd1, req_ready);
    @(negedge clk);
    for (int i = 0; i <= COLD_REQS; i++) begin
      if (i > 0) begin
        check_response("cold", exp);
        check_eq("cold: no slot", 64'd0, pred_slot_valid);
        check_eq("cold: next block", {req_pc[XLEN-1:4], 4'h0} + 32'd16, npc);
      end
      if (i < COLD_REQS) begin
        req_pc = $urandom & 32'hffff_fffc;
        exp = predict(req_pc);
        ifu_valid = 1'b1;
        fetch_pc = req_pc;
        check_eq("cold: req_ready", 64'd1, req_ready);  // One request per cycle.
        @(negedge clk);
      end
    end
    ifu_valid = 1'b0;
  endtask

  task automatic test_jumps();
    train(JMP_BASE + 32'd4, 1'b0, 1'b1, 32'h0000_2000, 1'b0, 1'b0);
    train(JMP_BASE + 32'd12, 1'b0, 1'b1, 32'h0000_3000, 1'b0, 1'b0);
    request("jumps: base", JMP_BASE);
    check_eq("jumps: base slot", 64'd1, pred_slot_idx);
    request("jumps: slot 2", JMP_BASE + 32'd8);
    check_eq("jumps: slot 2 slot", 64'd3, pred_slot_idx);
    request("jumps: tag mismatch", ALIAS_BASE);
    check_eq("jumps: tag mismatch slot", 64'd0, pred_slot_valid);
  endtask

  task automatic test_cond();
    train(COND_PC, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b0);  // Counter to 0, no BTB entry.
    train(ALIAS_BASE + 32'd4, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b0);  // Jump's BTB slot.
    request("cond: not allocated", JMP_BASE);
    train(COND_PC, 1'b1, 1'b1, 32'h0000_5000, 1'b0, 1'b0);
    request("cond: hit, weak", COND_BASE);
    check_eq("cond: hit, weak slot", 64'd0, pred_slot_valid);
    train(COND_PC, 1'b1, 1'b1, 32'h0000_5000, 1'b0, 1'b0);
    request("cond: taken", COND_BASE);
    check_eq("cond: taken slot", 64'd2, pred_slot_idx);
    train(COND_PC, 1'b1, 1'b1, 32'h0000_5000, 1'b0, 1'b0);
    train(COND_PC, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b0);
    request("cond: still taken", COND_BASE);
    check_eq("cond: still taken target", 32'h0000_5000, npc);
    train(COND_PC, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b0);
    request("cond: not taken", COND_BASE);
    check_eq("cond: not taken slot", 64'd0, pred_slot_valid);
  endtask

  task automatic test_ras();
    train(RET_PC, 1'b0, 1'b1, 32'h0000_7000, 1'b0, 1'b1);
    request("ras: empty", RET_BASE);
    check_eq("ras: empty target", 32'h0000_7000, pred_slot_target);
    retire(32'h0000_8000, 1'b1, 1'b0);
    retire(32'h0000_9010, 1'b1, 1'b0);
    request("ras: two calls", RET_BASE);
    check_eq("ras: two calls target", 32'h0000_9014, pred_slot_target);
    retire(32'h0000_9100, 1'b0, 1'b1);
    request("ras: one pop", RET_BASE);
    check_eq("ras: one pop target", 32'h0000_8004, npc);
  endtask

  task automatic test_backpressure_flush();
    bpu_to_ifu_t exp;
    @(negedge clk);
    ifu_ready = 1'b0;
    exp = predict(JMP_BASE);
    ifu_valid = 1'b1;
    fetch_pc = JMP_BASE;
    check_eq("bp: req_ready before accept", 64'd1, req_ready);
    @(negedge clk);
    fetch_pc = COND_BASE;  // Must not be accepted while stalled.
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      check_response("bp: held", exp);
      check_eq("bp: held slot", 64'd1, pred_slot_idx);
      check_eq("bp: req_ready stalled", 64'd0, req_ready);
      @(negedge clk);
    end
    flush = 1'b1;
    ifu_ready = 1'b1;  // Only the flush holds off the pending request.
    check_response("bp: before flush", exp);
    check_eq("bp: req_ready in flush", 64'd0, req_ready);
    @(negedge clk);
    flush = 1'b0;
    ifu_valid = 1'b0;
    check_eq("bp: pred_valid after flush", 64'd0, pred_valid);
    request("bp: after flush", RET_BASE);
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung.", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation timed out.");
  end

  initial begin
    void'($urandom(RAND_SEED));
    rst = 1'b1;
    ifu_valid = 1'b0;
    ifu_ready = 1'b1;
    fetch_pc = '0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_is_cond = 1'b0;
    upd_taken = 1'b0;
    upd_target = '0;
    upd_is_call = 1'b0;
    upd_is_ret = 1'b0;
    ras_valid = 1'b0;
    ras_is_call = 1'b0;
    ras_is_ret = 1'b0;
    ras_pc = '0;
    flush = 1'b0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    test_cold_tables();
    test_jumps();
    test_cond();
    test_ras();
    test_backpressure_flush();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+tb
rtl/bpu_pkg.sv
rtl/bpu_btb.sv
rtl/bpu_bht.sv
rtl/bpu_ras.sv
rtl/bpu.sv
rtl/bpu_top.sv
tb/tb_bpu_top.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - rtl/bpu_pkg.sv
      - rtl/bpu_btb.sv
      - rtl/bpu_bht.sv
      - rtl/bpu_ras.sv
      - rtl/bpu.sv
      - rtl/bpu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_bpu_top.sv
